/* hdl/rgbPkg.sv */
package rgbPkg;

    ////////////////////
    // data widths
    ////////////////////

    // switch bank width, one intensity word
    localparam int intensityWidth = 13;

    // stored duty is one bit wider than the switches
    // so the full 0..8191 range compares cleanly against the counter
    localparam int dutyWidth = intensityWidth + 1;

    ////////////////////
    // pwm timing
    ////////////////////

    localparam int pwmPeriod = 8192;     // clocks per period, counter runs 0..pwmPeriod-1

    ////////////////////
    // channel select
    ////////////////////

    // one-hot selector codes, anything else selects nothing
    localparam logic [2:0] selRed   = 3'b001;
    localparam logic [2:0] selGreen = 3'b010;
    localparam logic [2:0] selBlue  = 3'b100;

    ////////////////////
    // input sync
    ////////////////////

    localparam int syncStages = 2;       // flops per async input

endpackage

/* hdl/inputSync.sv */
`timescale 1ns/1ns

module inputSync
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              changeColor,     // raw button
    input  logic [2:0]                        colorSelector,   // raw one-hot switches
    input  logic [rgbPkg::intensityWidth-1:0] colorIntensity,  // raw intensity switches
    output logic                              loadPulse,       // one clock per press
    output logic [2:0]                        selSync,
    output logic [rgbPkg::intensityWidth-1:0] intensitySync
);

    import rgbPkg::*;

    // sync chains, index 0 samples the pin
    logic [syncStages-1:0]     btnStage;
    logic [2:0]                selStage [syncStages];
    logic [intensityWidth-1:0] intStage [syncStages];

    logic btnLast;    // synced button, one clock older
    logic btnRise;    // low-to-high on synced button

    ////////////////////
    // synchronizers
    ////////////////////

    // same depth on every input so switches and button line up
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            btnStage <= '0;
            for (int i = 0; i < syncStages; i++)
            begin
                selStage[i] <= '0;
                intStage[i] <= '0;
            end
        end
        else
        begin
            btnStage[0] <= changeColor;
            selStage[0] <= colorSelector;
            intStage[0] <= colorIntensity;
            for (int i = 1; i < syncStages; i++)
            begin
                btnStage[i] <= btnStage[i-1];   // shift toward output
                selStage[i] <= selStage[i-1];
                intStage[i] <= intStage[i-1];
            end
        end
    end

    assign selSync       = selStage[syncStages-1];
    assign intensitySync = intStage[syncStages-1];

    ////////////////////
    // edge detect
    ////////////////////

    assign btnRise = btnStage[syncStages-1] & ~btnLast;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            btnLast   <= 1'b0;
            loadPulse <= 1'b0;
        end
        else
        begin
            btnLast   <= btnStage[syncStages-1];
            loadPulse <= btnRise;    // held button gives a single strobe
        end
    end

endmodule

/* hdl/colorRegs.sv */
`timescale 1ns/1ns

module colorRegs
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              loadPulse,      // single-cycle write strobe
    input  logic [2:0]                        selSync,        // one-hot channel pick
    input  logic [rgbPkg::intensityWidth-1:0] intensitySync,
    output logic [rgbPkg::dutyWidth-1:0]      redDuty,
    output logic [rgbPkg::dutyWidth-1:0]      greenDuty,
    output logic [rgbPkg::dutyWidth-1:0]      blueDuty
);

    import rgbPkg::*;

    logic [dutyWidth-1:0] loadValue;    // intensity widened to duty width
    logic                 wrRed;
    logic                 wrGreen;
    logic                 wrBlue;

    // zero-extend, top bit of a duty is always clear here
    assign loadValue = dutyWidth'(intensitySync);

    ////////////////////
    // selector decode
    ////////////////////

    always_comb
    begin
        wrRed   = 1'b0;
        wrGreen = 1'b0;
        wrBlue  = 1'b0;
        case (selSync)
            selRed:   wrRed   = loadPulse;
            selGreen: wrGreen = loadPulse;
            selBlue:  wrBlue  = loadPulse;
            default:  ;    // zero or several bits set, no channel written
        endcase
    end

    ////////////////////
    // channel registers
    ////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            redDuty   <= '0;    // all channels dark
            greenDuty <= '0;
            blueDuty  <= '0;
        end
        else
        begin
            if (wrRed)
                redDuty <= loadValue;
            if (wrGreen)
                greenDuty <= loadValue;
            if (wrBlue)
                blueDuty <= loadValue;
            // unselected channels hold
        end
    end

endmodule

/* hdl/rgbDriver.sv */
`timescale 1ns/1ns

module rgbDriver
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic [rgbPkg::dutyWidth-1:0] redDuty,     // live channel values
    input  logic [rgbPkg::dutyWidth-1:0] greenDuty,
    input  logic [rgbPkg::dutyWidth-1:0] blueDuty,
    output logic                         redLed,
    output logic                         greenLed,
    output logic                         blueLed
);

    import rgbPkg::*;

    // channel order in the arrays: 0 red, 1 green, 2 blue
    localparam int numChannels = 3;

    logic [dutyWidth-1:0] periodCnt;                  // shared by all channels
    logic                 periodEnd;                  // last clock of a period
    logic [dutyWidth-1:0] dutyIn     [numChannels];
    logic [dutyWidth-1:0] dutyShadow [numChannels];   // value used this period
    logic [numChannels-1:0] pwmOut;

    ////////////////////
    // period counter
    ////////////////////

    assign periodEnd = (periodCnt == dutyWidth'(pwmPeriod - 1));

    // free running, wraps to zero after pwmPeriod clocks
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            periodCnt <= '0;
        else if (periodEnd)
            periodCnt <= '0;
        else
            periodCnt <= periodCnt + 1'b1;
    end

    ////////////////////
    // duty shadows
    ////////////////////

    assign dutyIn[0] = redDuty;
    assign dutyIn[1] = greenDuty;
    assign dutyIn[2] = blueDuty;

    // take new duties only at the wrap
    // a load in mid-period waits, so no pulse gets clipped
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < numChannels; i++)
            begin
                dutyShadow[i] <= '0;
            end
        end
        else if (periodEnd)
        begin
            for (int i = 0; i < numChannels; i++)
            begin
                dutyShadow[i] <= dutyIn[i];
            end
        end
    end

    ////////////////////
    // pwm compare
    ////////////////////

    // high while counter below duty, so high count per period = duty
    // one clock behind the counter, still exact over any full period
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pwmOut <= '0;
        end
        else
        begin
            for (int i = 0; i < numChannels; i++)
            begin
                pwmOut[i] <= (periodCnt < dutyShadow[i]);
            end
        end
    end

    assign redLed   = pwmOut[0];
    assign greenLed = pwmOut[1];
    assign blueLed  = pwmOut[2];

endmodule

/* hdl/rgbTop.sv */
`timescale 1ns/1ns

module rgbTop
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              changeColor,     // load button, async
    input  logic [2:0]                        colorSelector,   // one-hot channel switches
    input  logic [rgbPkg::intensityWidth-1:0] colorIntensity,  // intensity switches
    output logic                              redLed,
    output logic                              greenLed,
    output logic                              blueLed
);

    import rgbPkg::*;

    // synced inputs
    logic                      loadPulse;
    logic [2:0]                selSync;
    logic [intensityWidth-1:0] intensitySync;

    // stored channel duties
    logic [dutyWidth-1:0] redDuty;
    logic [dutyWidth-1:0] greenDuty;
    logic [dutyWidth-1:0] blueDuty;

    ////////////////////
    // input side
    ////////////////////

    inputSync uInputSync
    (
        .clk            (clk),
        .reset          (reset),
        .changeColor    (changeColor),
        .colorSelector  (colorSelector),
        .colorIntensity (colorIntensity),
        .loadPulse      (loadPulse),
        .selSync        (selSync),
        .intensitySync  (intensitySync)
    );

    colorRegs uColorRegs
    (
        .clk           (clk),
        .reset         (reset),
        .loadPulse     (loadPulse),
        .selSync       (selSync),
        .intensitySync (intensitySync),
        .redDuty       (redDuty),
        .greenDuty     (greenDuty),
        .blueDuty      (blueDuty)
    );

    ////////////////////
    // led side
    ////////////////////

    rgbDriver uRgbDriver
    (
        .clk       (clk),
        .reset     (reset),
        .redDuty   (redDuty),
        .greenDuty (greenDuty),
        .blueDuty  (blueDuty),
        .redLed    (redLed),
        .greenLed  (greenLed),
        .blueLed   (blueLed)
    );

endmodule

/* sim/rgbTop_props.sv */
`timescale 1ns/1ns

module rgbTopProps
(
    input logic clk,
    input logic reset,
    input logic loadPulse,    // internal strobe of rgbTop
    input logic redLed,
    input logic greenLed,
    input logic blueLed
);

    // leds dark through reset
    ledsDarkInReset: assert property (@(posedge clk)
        reset |-> !(redLed || greenLed || blueLed))
        else $error("led high while reset is active");

    // one strobe per button edge
    singleLoadPulse: assert property (@(posedge clk) disable iff (reset)
        loadPulse |=> !loadPulse)
        else $error("load strobe high on two consecutive clocks");

    // outputs only move once out of reset
    ledChangeAfterReset: assert property (@(posedge clk)
        $changed({redLed, greenLed, blueLed}) |-> !$past(reset))
        else $error("led output changed while reset was active");

endmodule

bind rgbTop rgbTopProps props
(
    .clk       (clk),
    .reset     (reset),
    .loadPulse (loadPulse),
    .redLed    (redLed),
    .greenLed  (greenLed),
    .blueLed   (blueLed)
);

/* sim/rgbTopTb.sv */
`timescale 1ns/1ns

module rgbTopTb;

    import rgbPkg::*;

    localparam int settleClocks = 2 * pwmPeriod + 16;   // two periods plus margin
    localparam int syncClocks   = 6;                     // sync chain plus edge detect

    logic                      clk;
    logic                      reset;
    logic                      changeColor;
    logic [2:0]                colorSelector;
    logic [intensityWidth-1:0] colorIntensity;
    logic                      redLed;
    logic                      greenLed;
    logic                      blueLed;

    // stimulus table, one entry per step
    string                     rowName    [$];
    logic [2:0]                rowSel     [$];
    logic [intensityWidth-1:0] rowValue   [$];
    bit                        rowDrop    [$];   // release button before the step
    bit                        rowRandom  [$];   // value from lfsr, expect from model
    int                        rowRed     [$];
    int                        rowGreen   [$];
    int                        rowBlue    [$];

    int          expRed;        // reference model of the channels
    int          expGreen;
    int          expBlue;
    logic [31:0] lfsrState;
    int          errors;
    int          checks;

    rgbTop dut
    (
        .clk            (clk),
        .reset          (reset),
        .changeColor    (changeColor),
        .colorSelector  (colorSelector),
        .colorIntensity (colorIntensity),
        .redLed         (redLed),
        .greenLed       (greenLed),
        .blueLed        (blueLed)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;    // 4 ns period
    end

    ////////////////////
    // helpers
    ////////////////////

    // x^32 + x^22 + x^2 + x + 1, new bit enters at lsb
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic nextIntensity(output logic [intensityWidth-1:0] value);
        value = '0;
        for (int i = 0; i < intensityWidth; i++)
        begin
            lfsrState = lfsrStep(lfsrState);    // one step per bit
            value     = {value[intensityWidth-2:0], lfsrState[0]};
        end
    endtask

    task automatic addRow(input string name, input logic [2:0] sel, input int value,
                          input bit drop, input bit fromLfsr,
                          input int r, input int g, input int b);
        rowName.push_back(name);
        rowSel.push_back(sel);
        rowValue.push_back(value[intensityWidth-1:0]);
        rowDrop.push_back(drop);
        rowRandom.push_back(fromLfsr);
        rowRed.push_back(r);
        rowGreen.push_back(g);
        rowBlue.push_back(b);
    endtask

    // counted wait, the count bounds it
    task automatic waitClocks(input int cycles);
        int n;
        n = 0;
        while (n < cycles)
        begin
            @(posedge clk);
            n++;
        end
    endtask

    task automatic checkCount(input string name, input string led,
                              input int expected, input int actual);
        checks++;
        assert (actual == expected)
        else
        begin
            $display("FAILED %s %s expected %0d actual %0d", name, led, expected, actual);
            errors++;
        end
    endtask

    // high cycles over exactly one period, any phase works once duty is steady
    task automatic measureAndCheck(input string name, input int r, input int g, input int b);
        int redHigh;
        int greenHigh;
        int blueHigh;
        redHigh   = 0;
        greenHigh = 0;
        blueHigh  = 0;
        for (int n = 0; n < pwmPeriod; n++)
        begin
            @(negedge clk);    // mid-cycle, outputs stable
            if (redLed)
                redHigh++;
            if (greenLed)
                greenHigh++;
            if (blueLed)
                blueHigh++;
        end
        checkCount(name, "red", r, redHigh);
        checkCount(name, "green", g, greenHigh);
        checkCount(name, "blue", b, blueHigh);
    endtask

    task automatic applyStep(input int idx);
        logic [intensityWidth-1:0] value;
        if (rowRandom[idx])
            nextIntensity(value);
        else
            value = rowValue[idx];
        if (rowDrop[idx])
        begin
            @(posedge clk);
            changeColor <= 1'b0;
            waitClocks(syncClocks);
        end
        @(posedge clk);
        colorSelector  <= rowSel[idx];
        colorIntensity <= value;
        waitClocks(syncClocks);    // switches through sync before the edge
        @(posedge clk);
        changeColor <= 1'b1;       // stays held until the next drop
        if (rowRandom[idx])
        begin
            case (rowSel[idx])
                selRed:   expRed   = int'(value);
                selGreen: expGreen = int'(value);
                selBlue:  expBlue  = int'(value);
                default:  ;        // no channel picked
            endcase
        end
        else
        begin
            expRed   = rowRed[idx];
            expGreen = rowGreen[idx];
            expBlue  = rowBlue[idx];
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial
    begin
        reset          = 1'b1;
        changeColor    = 1'b0;
        colorSelector  = '0;
        colorIntensity = '0;
        lfsrState      = 32'hb45a_579b;
        errors         = 0;
        checks         = 0;
        expRed         = 0;
        expGreen       = 0;
        expBlue        = 0;

        // name, sel, value, drop, random, red, green, blue
        addRow("redZero",    selRed,   0,    1'b1, 1'b0, 0,    0,    0);
        addRow("redOne",     selRed,   1,    1'b1, 1'b0, 1,    0,    0);
        addRow("green4096",  selGreen, 4096, 1'b1, 1'b0, 1,    4096, 0);
        addRow("blueMax",    selBlue,  8191, 1'b1, 1'b0, 1,    4096, 8191);
        addRow("redMax",     selRed,   8191, 1'b1, 1'b0, 8191, 4096, 8191);
        addRow("greenZero",  selGreen, 0,    1'b1, 1'b0, 8191, 0,    8191);
        addRow("blueOne",    selBlue,  1,    1'b1, 1'b0, 8191, 0,    1);
        addRow("selNone",    3'b000,   1234, 1'b1, 1'b0, 8191, 0,    1);
        addRow("selRedGrn",  3'b011,   2222, 1'b1, 1'b0, 8191, 0,    1);
        addRow("selRedBlu",  3'b101,   3333, 1'b1, 1'b0, 8191, 0,    1);
        addRow("selAll",     3'b111,   4444, 1'b1, 1'b0, 8191, 0,    1);
        addRow("greenFirst", selGreen, 100,  1'b1, 1'b0, 8191, 100,  1);
        addRow("greenHeld",  selGreen, 5000, 1'b0, 1'b0, 8191, 100,  1);   // no new edge
        addRow("greenAgain", selGreen, 5000, 1'b1, 1'b0, 8191, 5000, 1);
        addRow("randRed",    selRed,   0,    1'b1, 1'b1, 0,    0,    0);
        addRow("randGreen",  selGreen, 0,    1'b1, 1'b1, 0,    0,    0);
        addRow("randBlue",   selBlue,  0,    1'b1, 1'b1, 0,    0,    0);
        addRow("randRed2",   selRed,   0,    1'b1, 1'b1, 0,    0,    0);
        addRow("randGreen2", selGreen, 0,    1'b1, 1'b1, 0,    0,    0);
        addRow("randBlue2",  selBlue,  0,    1'b1, 1'b1, 0,    0,    0);

        waitClocks(5);
        reset <= 1'b0;

        // idle after reset, nothing loaded
        waitClocks(settleClocks);
        measureAndCheck("afterReset", 0, 0, 0);

        for (int i = 0; i < rowName.size(); i++)
        begin
            applyStep(i);
            waitClocks(settleClocks);    // new duty at outputs within two periods
            measureAndCheck(rowName[i], expRed, expGreen, expBlue);
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* vlog.f */
hdl/rgbPkg.sv
hdl/inputSync.sv
hdl/colorRegs.sv
hdl/rgbDriver.sv
hdl/rgbTop.sv
sim/rgbTop_props.sv
sim/rgbTopTb.sv

/* runSim.sh */
#!/bin/sh
# build and run the rgbTop testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module rgbTopTb \
    -f vlog.f -o rgbTopSim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/rgbTopSim > sim.log 2>&1 \
    || echo "simulator returned an error status"

grep -qs '^>>> PASS$' sim.log \
    && { echo "simulation passed, see sim.log"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }
